//--- common/icap_pkg.sv
`default_nettype none

`include "multiboot_defs.svh"

package icap_pkg;

   typedef enum logic [1:0]
   {
      ICAP_OP_NOOP  = 2'b00,
      ICAP_OP_READ  = 2'b01,
      ICAP_OP_WRITE = 2'b10
   } icap_op_e;

   // Type 1 packet header, MSB first
   typedef struct packed
   {
      logic [2:0] pkt_type;
      icap_op_e   opcode;
      logic [5:0] reg_addr;
      logic [4:0] word_cnt;
   } icap_hdr_t;

   typedef union packed
   {
      logic [`ICAP_W-1:0] raw;
      icap_hdr_t          hdr;
   } icap_word_t;

   localparam logic [2:0] ICAP_TYPE1    = 3'b001;
   localparam logic [5:0] ICAP_REG_CMD  = 6'h05;
   localparam logic [5:0] ICAP_REG_GEN1 = 6'h13;
   localparam logic [5:0] ICAP_REG_GEN2 = 6'h14;
   localparam logic [5:0] ICAP_REG_GEN5 = 6'h17;

   function automatic icap_word_t icap_type1(icap_op_e op, logic [5:0] addr, logic [4:0] cnt);
      icap_word_t w;
      w.hdr.pkt_type = ICAP_TYPE1;
      w.hdr.opcode   = op;
      w.hdr.reg_addr = addr;
      w.hdr.word_cnt = cnt;
      return w;
   endfunction

   // ICAP takes D0 first, so each byte is mirrored
   function automatic icap_word_t icap_bit_swap(icap_word_t w);
      icap_word_t s;
      for (int i = 0; i < 8; i++)
      begin
         s.raw[i]     = w.raw[7-i];
         s.raw[8+i]   = w.raw[15-i];
      end
      return s;
   endfunction

endpackage

`default_nettype wire

//--- common/multiboot_defs.svh
`ifndef MULTIBOOT_DEFS_SVH
`define MULTIBOOT_DEFS_SVH

// ---------------------------------------------------------------------------
// Widths and startup delay
// ---------------------------------------------------------------------------
`define ICAP_W          16
`define DIP_W           8
`define DESIGN_W        5
`define STARTUP_CYCLES  15          // Clocks before the readback starts

// ---------------------------------------------------------------------------
// Configuration words, unswapped
// ---------------------------------------------------------------------------
`define ICAP_NULL       16'hFFFF
`define ICAP_SYNC_H     16'hAA99    // Sync word part 1
`define ICAP_SYNC_L     16'h5566    // Sync word part 2
`define ICAP_NOOP       16'h2000
`define ICAP_WR_CMD     16'h30A1    // Type 1 write, CMD register
`define ICAP_WR_GEN1    16'h3261
`define ICAP_WR_GEN2    16'h3281
`define ICAP_WR_GEN5    16'h32E1
`define ICAP_RD_GEN5    16'h2AE1    // Type 1 read, one word
`define CMD_REBOOT      16'h000E
`define CMD_DESYNC      16'h000D

// Fallback entry for design numbers not in the table
`define BOOT_GEN1_DEFAULT  16'h4000
`define BOOT_GEN2_DEFAULT  16'h032F

`endif

//--- common/multiboot_pkg.sv
`default_nettype none

`include "multiboot_defs.svh"

package multiboot_pkg;

   typedef logic [`DESIGN_W-1:0] design_num_t;

   // Soft DIP byte as kept in GENERAL_5
   typedef struct packed
   {
      logic [`DIP_W/2-1:0] pwr;      // High nibble
      logic [`DIP_W/2-1:0] sw;       // Low nibble
   } soft_dip_t;

   typedef struct packed
   {
      logic [`ICAP_W-1:0] gen1;
      logic [`ICAP_W-1:0] gen2;
   } boot_addr_t;

endpackage

`default_nettype wire

//--- icap_sequencer/icap_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

`include "multiboot_defs.svh"

module icap_sequencer
   import icap_pkg::*;
   import multiboot_pkg::*;
(
   input  wire logic       clk_16M00,
   input  wire logic       rst,
   input  wire logic       reconfig_valid,
   output logic            reconfig_ready,
   output logic            req_accept,
   input  wire boot_addr_t boot_addr,
   input  wire icap_word_t gen5_word,
   output logic            dip_capture,
   output soft_dip_t       dip_data,
   output icap_word_t      icap_din,
   output logic            icap_ce,
   output logic            icap_wr,
   input  wire icap_word_t icap_dout,
   input  wire logic       icap_busy
);

   localparam int CNT_W = $clog2(`STARTUP_CYCLES + 1);

   // Order matters, most states step to the next value
   typedef enum logic [5:0]
   {
      ST_WAIT,
      ST_RD_NULL, ST_RD_SYNC_H, ST_RD_SYNC_L, ST_RD_NOOP_0, ST_RD_NOOP_1,
      ST_RD_HDR, ST_RD_NOOP_2, ST_RD_NOOP_3, ST_RD_NOOP_4, ST_RD_NOOP_5,
      ST_RD_CE_OFF, ST_RD_WR_OFF, ST_RD_CE_ON, ST_RD_LATCH, ST_RD_ABORT,
      ST_RD_CMD_H, ST_RD_DESYNC, ST_RD_NOOP_6, ST_RD_NOOP_7,
      ST_IDLE,
      ST_RB_NULL, ST_RB_SYNC_H, ST_RB_SYNC_L, ST_RB_GEN1_H, ST_RB_GEN1_D,
      ST_RB_GEN2_H, ST_RB_GEN2_D, ST_RB_GEN5_H, ST_RB_GEN5_D, ST_RB_CMD_H,
      ST_RB_REBOOT, ST_RB_NOOP_0, ST_RB_NOOP_1, ST_RB_NOOP_2, ST_RB_NOOP_3,
      ST_RB_NULL_END
   } state_t;

   state_t           state;
   state_t           next_state;
   logic [CNT_W-1:0] startup_cnt;
   icap_word_t       word_nxt;
   logic             ce_nxt;
   logic             wr_nxt;
   icap_word_t       dout_unswapped;

   assign reconfig_ready = (state == ST_IDLE);
   assign req_accept     = reconfig_valid && reconfig_ready;

   assign dout_unswapped = icap_bit_swap(icap_dout);
   assign dip_capture    = (state == ST_RD_LATCH) && !icap_busy;
   assign dip_data       = soft_dip_t'(dout_unswapped.raw[`DIP_W-1:0]);

   // ------------------------------------------------------------------------
   // Next state and ICAP word
   // ------------------------------------------------------------------------
   always_comb
   begin
      next_state    = state_t'(state + 6'd1);
      word_nxt.raw  = `ICAP_NULL;
      ce_nxt        = 1'b0;                // Active low, write by default
      wr_nxt        = 1'b0;
      case (state)
         ST_WAIT:
         begin
            ce_nxt = 1'b1;
            wr_nxt = 1'b1;
            if (startup_cnt != CNT_W'(`STARTUP_CYCLES - 1))
               next_state = ST_WAIT;
         end
         ST_RD_SYNC_H, ST_RB_SYNC_H: word_nxt.raw = `ICAP_SYNC_H;
         ST_RD_SYNC_L, ST_RB_SYNC_L: word_nxt.raw = `ICAP_SYNC_L;
         ST_RD_NOOP_0, ST_RD_NOOP_1, ST_RD_NOOP_2, ST_RD_NOOP_3, ST_RD_NOOP_4,
         ST_RD_NOOP_5, ST_RD_NOOP_6, ST_RD_NOOP_7,
         ST_RB_NOOP_0, ST_RB_NOOP_1, ST_RB_NOOP_2, ST_RB_NOOP_3:
            word_nxt.raw = `ICAP_NOOP;
         ST_RD_HDR:    word_nxt = icap_type1(ICAP_OP_READ, ICAP_REG_GEN5, 5'd1);
         ST_RD_CE_OFF: ce_nxt = 1'b1;      // Drop CE before turning the bus
         ST_RD_WR_OFF:
         begin
            ce_nxt = 1'b1;
            wr_nxt = 1'b1;
         end
         ST_RD_CE_ON:  wr_nxt = 1'b1;      // Read enabled
         ST_RD_LATCH:
         begin
            wr_nxt = 1'b1;
            if (icap_busy)
               next_state = ST_RD_LATCH;   // Hold read until data valid
            else
               ce_nxt = 1'b1;
         end
         ST_RD_ABORT:  ce_nxt = 1'b1;      // Back to write with CE high
         ST_RD_CMD_H, ST_RB_CMD_H:
            word_nxt = icap_type1(ICAP_OP_WRITE, ICAP_REG_CMD, 5'd1);
         ST_RD_DESYNC: word_nxt.raw = `CMD_DESYNC;
         ST_IDLE:
         begin
            ce_nxt = 1'b1;
            wr_nxt = 1'b1;
            if (!req_accept)
               next_state = ST_IDLE;
         end
         ST_RB_GEN1_H: word_nxt = icap_type1(ICAP_OP_WRITE, ICAP_REG_GEN1, 5'd1);
         ST_RB_GEN1_D: word_nxt.raw = boot_addr.gen1;
         ST_RB_GEN2_H: word_nxt = icap_type1(ICAP_OP_WRITE, ICAP_REG_GEN2, 5'd1);
         ST_RB_GEN2_D: word_nxt.raw = boot_addr.gen2;
         ST_RB_GEN5_H: word_nxt = icap_type1(ICAP_OP_WRITE, ICAP_REG_GEN5, 5'd1);
         ST_RB_GEN5_D: word_nxt = gen5_word;
         ST_RB_REBOOT: word_nxt.raw = `CMD_REBOOT;
         ST_RB_NULL_END: next_state = ST_IDLE;
         default: ;                        // Null word writes
      endcase
   end

   always_ff @(posedge clk_16M00)
   begin
      if (rst)
      begin
         state       <= ST_WAIT;
         startup_cnt <= '0;
      end
      else
      begin
         state <= next_state;
         if (state == ST_WAIT)
            startup_cnt <= startup_cnt + 1'b1;
      end
   end

   // ICAP output register, word goes out swapped
   always_ff @(posedge clk_16M00)
   begin
      if (rst)
      begin
         icap_din.raw <= `ICAP_NULL;
         icap_ce      <= 1'b1;
         icap_wr      <= 1'b1;
      end
      else
      begin
         icap_din <= icap_bit_swap(word_nxt);
         icap_ce  <= ce_nxt;
         icap_wr  <= wr_nxt;
      end
   end

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------
   a_state_legal: assert property (@(posedge clk_16M00) disable iff (rst)
      state <= ST_RB_NULL_END);

   // Ready only comes up at the end of a readback or reboot sequence
   a_ready_rise: assert property (@(posedge clk_16M00) disable iff (rst)
      $rose(reconfig_ready) |->
         ($past(state) == ST_RD_NOOP_7) || ($past(state) == ST_RB_NULL_END));

   a_capture_pulse: assert property (@(posedge clk_16M00) disable iff (rst)
      dip_capture |=> !dip_capture);

endmodule

`default_nettype wire

//--- src.f
+incdir+common
common/icap_pkg.sv
common/multiboot_pkg.sv
icap_sequencer/icap_sequencer.sv
verilog/boot_image_table.sv
verilog/soft_dip_store.sv
verilog/multiboot_ctrl.sv
testbench/tb_icap_model.sv
testbench/tb_multiboot_ctrl.sv

//--- testbench/tb_icap_model.sv
`default_nettype none
`timescale 1ns/1ps

`include "multiboot_defs.svh"

module tb_icap_model
   import icap_pkg::*;
(
   input  wire logic       clk_16M00,
   input  wire logic       rst,
   input  wire icap_word_t icap_din,
   input  wire logic       icap_ce,
   input  wire logic       icap_wr,
   output icap_word_t      icap_dout,
   output logic            icap_busy,
   input  wire logic [7:0] gen5_byte
);

   logic [15:0] log_mem [0:255];           // Written words after the unswap
   int          log_cnt;
   int          read_cnt;
   int          busy_len;
   logic        reading;
   integer      seed;

   initial
   begin
      seed          = 32'hffef7e20;
      icap_busy     = 1'b1;
      icap_dout.raw = `ICAP_NULL;
   end

   // Mirrors each byte in both directions
   function automatic logic [15:0] mirror_bytes(input logic [15:0] v);
      logic [15:0] m;
      for (int i = 0; i < 16; i++)
         m[i] = v[(i & 8) + 7 - (i & 7)];
      return m;
   endfunction

   always @(posedge clk_16M00)
   begin
      if (rst)
      begin
         log_cnt       <= 0;
         reading       <= 1'b0;
         read_cnt      <= 0;
         icap_busy     <= 1'b1;
         icap_dout.raw <= `ICAP_NULL;
      end
      else
      begin
         if (!icap_ce && !icap_wr)
         begin
            log_mem[log_cnt] <= mirror_bytes(icap_din.raw);
            log_cnt          <= log_cnt + 1;
         end
         if (!icap_ce && icap_wr)          // Read cycle
         begin
            reading <= 1'b1;
            if (!reading)
            begin
               busy_len  <= 1 + ($unsigned($random(seed)) % 6);
               read_cnt  <= 1;
               icap_busy <= 1'b1;
            end
            else if (read_cnt < busy_len)
               read_cnt <= read_cnt + 1;
            else
            begin
               icap_busy     <= 1'b0;       // GENERAL_5 data valid
               icap_dout.raw <= mirror_bytes({8'hC3, gen5_byte});
            end
         end
         else
         begin
            reading       <= 1'b0;
            icap_busy     <= 1'b1;
            icap_dout.raw <= `ICAP_NULL;
         end
      end
   end

endmodule

`default_nettype wire

//--- testbench/tb_multiboot_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "multiboot_defs.svh"

module tb_multiboot_ctrl
   import icap_pkg::*;
   import multiboot_pkg::*;
();

   localparam int MAX_CYCLES = 2000;       // Tests need about 400 cycles

   logic        clk_16M00;
   logic        rst;
   logic        reconfig_valid;
   logic        reconfig_ready;
   design_num_t design_num;
   logic        powerup;
   logic [3:0]  sw_in;
   logic [3:0]  sw_out;
   logic [3:0]  pwr_out;
   icap_word_t  icap_din;
   logic        icap_ce;
   logic        icap_wr;
   icap_word_t  icap_dout;
   logic        icap_busy;
   logic [7:0]  dip_prog;                  // GENERAL_5 byte the model returns
   soft_dip_t   dip_stored;
   int          err_cnt;
   int          check_cnt;
   int          cycle_cnt;
   int          log_rd;

   multiboot_ctrl multiboot_ctrl_i
   (
      .clk_16M00      (clk_16M00),
      .rst            (rst),
      .reconfig_valid (reconfig_valid),
      .reconfig_ready (reconfig_ready),
      .design_num     (design_num),
      .powerup        (powerup),
      .sw_in          (sw_in),
      .sw_out         (sw_out),
      .pwr_out        (pwr_out),
      .icap_din       (icap_din),
      .icap_ce        (icap_ce),
      .icap_wr        (icap_wr),
      .icap_dout      (icap_dout),
      .icap_busy      (icap_busy)
   );

   tb_icap_model icap_model_i
   (
      .clk_16M00 (clk_16M00),
      .rst       (rst),
      .icap_din  (icap_din),
      .icap_ce   (icap_ce),
      .icap_wr   (icap_wr),
      .icap_dout (icap_dout),
      .icap_busy (icap_busy),
      .gen5_byte (dip_prog)
   );

   initial
      clk_16M00 = 1'b0;

   always
      #2 clk_16M00 = ~clk_16M00;          // 4 ns period

   // ------------------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------------------
   task automatic check_word(input string name, input icap_word_t exp, input icap_word_t act);
      check_cnt++;
      if (act.raw !== exp.raw)
      begin
         err_cnt++;
         $display("** Error %s: expected %h, actual %h", name, exp.raw, act.raw);
      end
   endtask

   task automatic check_dip(input string name, input soft_dip_t exp, input soft_dip_t act);
      check_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      check_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         $display("** Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // Next word of the ICAP write log
   task automatic expect_log(input string name, input icap_word_t exp);
      if (log_rd >= icap_model_i.log_cnt)
      begin
         err_cnt++;
         $display("%s: the ICAP never saw the write of %h", name, exp.raw);
      end
      else
         check_word(name, exp, icap_model_i.log_mem[log_rd]);
      log_rd++;
   endtask

   // ------------------------------------------------------------------------
   // Stimulus helpers
   // ------------------------------------------------------------------------
   task automatic reset_dut();
      @(posedge clk_16M00);
      rst <= 1'b1;
      repeat (2) @(posedge clk_16M00);
      rst <= 1'b0;
      log_rd = 0;
   endtask

   task automatic wait_ready(output int cycles);
      cycles = 0;
      @(negedge clk_16M00);
      while (!reconfig_ready)
      begin
         cycles++;
         @(negedge clk_16M00);
      end
   endtask

   // Returns on the accepting edge
   task automatic send_request(input design_num_t num, output int held);
      held = 0;
      @(posedge clk_16M00);
      reconfig_valid <= 1'b1;
      design_num     <= num;
      @(negedge clk_16M00);
      while (!reconfig_ready)
      begin
         held++;
         @(negedge clk_16M00);
      end
      @(posedge clk_16M00);
      reconfig_valid <= 1'b0;
   endtask

   task automatic expect_reboot(input string name, input logic [15:0] gen1,
                                input logic [15:0] gen2, input logic [15:0] gen5);
      expect_log({name, " null"}, `ICAP_NULL);
      expect_log({name, " sync h"}, `ICAP_SYNC_H);
      expect_log({name, " sync l"}, `ICAP_SYNC_L);
      expect_log({name, " gen1 hdr"}, `ICAP_WR_GEN1);
      expect_log({name, " gen1"}, gen1);
      expect_log({name, " gen2 hdr"}, `ICAP_WR_GEN2);
      expect_log({name, " gen2"}, gen2);
      expect_log({name, " gen5 hdr"}, `ICAP_WR_GEN5);
      expect_log({name, " gen5"}, gen5);
      expect_log({name, " cmd hdr"}, `ICAP_WR_CMD);
      expect_log({name, " reboot"}, `CMD_REBOOT);
      repeat (4) expect_log({name, " noop"}, `ICAP_NOOP);
      expect_log({name, " null end"}, `ICAP_NULL);
   endtask

   // ------------------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------------------
   task automatic readback_test(input string name, input logic [7:0] prog);
      int cycles;
      @(posedge clk_16M00);
      dip_prog <= prog;
      powerup  <= 1'b0;
      reset_dut();
      @(negedge clk_16M00);
      check_bit({name, " ready low"}, 1'b0, reconfig_ready);
      check_bit({name, " ce idle"}, 1'b1, icap_ce);
      check_bit({name, " wr idle"}, 1'b1, icap_wr);
      check_word({name, " din idle"}, `ICAP_NULL, icap_din);
      check_dip({name, " dip cleared"}, 8'h00, {pwr_out, sw_out});
      wait_ready(cycles);
      // All readback words but the last NOOP are logged by now
      check_bit({name, " ready after desync"}, 1'b1, icap_model_i.log_cnt == 13);
      @(negedge clk_16M00);                // Last NOOP reaches the log
      expect_log({name, " null"}, `ICAP_NULL);
      expect_log({name, " sync h"}, `ICAP_SYNC_H);
      expect_log({name, " sync l"}, `ICAP_SYNC_L);
      repeat (2) expect_log({name, " noop"}, `ICAP_NOOP);
      expect_log({name, " gen5 read"}, `ICAP_RD_GEN5);
      repeat (4) expect_log({name, " noop"}, `ICAP_NOOP);
      expect_log({name, " cmd hdr"}, `ICAP_WR_CMD);
      expect_log({name, " desync"}, `CMD_DESYNC);
      repeat (2) expect_log({name, " noop"}, `ICAP_NOOP);
      check_bit({name, " no extra writes"}, 1'b1, log_rd == icap_model_i.log_cnt);
      dip_stored = prog;
      check_dip({name, " soft dip"}, prog, {pwr_out, sw_out});
   endtask

   task automatic reboot_test(input string name, input design_num_t num,
                              input logic [15:0] gen1, input logic [15:0] gen2);
      int          held;
      int          cycles;
      logic [15:0] gen5;
      gen5 = powerup ? {8'h00, sw_in, sw_in} : {8'h00, dip_stored.pwr, num[3:0]};
      send_request(num, held);
      check_bit({name, " accepted at once"}, 1'b1, held == 0);
      wait_ready(cycles);
      check_bit({name, " 16 cycles"}, 1'b1, cycles == 16);
      @(negedge clk_16M00);
      expect_reboot(name, gen1, gen2, gen5);
      check_bit({name, " one sequence"}, 1'b1, log_rd == icap_model_i.log_cnt);
   endtask

   task automatic powerup_test();
      @(posedge clk_16M00);
      powerup <= 1'b1;
      sw_in   <= 4'h9;
      @(negedge clk_16M00);
      check_dip("powerup override 9", 8'h99, {pwr_out, sw_out});
      @(posedge clk_16M00);
      sw_in <= 4'h6;
      @(negedge clk_16M00);
      check_dip("powerup override 6", 8'h66, {pwr_out, sw_out});
      reboot_test("reboot under powerup", 5'd6, 16'h4000, 16'h032F);
      @(posedge clk_16M00);
      powerup <= 1'b0;
      @(negedge clk_16M00);
      check_dip("powerup released", dip_stored, {pwr_out, sw_out});
   endtask

   // Second request waits out the first reboot
   task automatic backpressure_test();
      int held;
      int cycles;
      send_request(5'd5, held);
      check_bit("backpressure first at once", 1'b1, held == 0);
      send_request(5'd13, held);
      check_bit("backpressure held", 1'b1, held > 0);
      wait_ready(cycles);
      check_bit("backpressure 16 cycles", 1'b1, cycles == 16);
      @(negedge clk_16M00);
      expect_reboot("backpressure first", 16'h8000, 16'h0334, {8'h00, dip_stored.pwr, 4'h5});
      expect_reboot("backpressure second", 16'hC000, 16'h0324, {8'h00, dip_stored.pwr, 4'hD});
      check_bit("backpressure one sequence each", 1'b1, log_rd == icap_model_i.log_cnt);
   endtask

   initial
   begin
      rst            = 1'b1;
      reconfig_valid = 1'b0;
      design_num     = '0;
      powerup        = 1'b0;
      sw_in          = 4'h0;
      dip_prog       = 8'h00;
      dip_stored     = '0;
      err_cnt        = 0;
      check_cnt      = 0;
      log_rd         = 0;
      readback_test("startup readback", 8'h5A);
      readback_test("soft dip 08", 8'h08);
      readback_test("soft dip a7", 8'hA7);
      readback_test("soft dip 3c", 8'h3C);
      readback_test("soft dip e1", 8'hE1);
      powerup_test();
      reboot_test("reboot design 0", 5'd0, 16'h4000, 16'h0305);
      reboot_test("reboot design 5", 5'd5, 16'h8000, 16'h0334);
      reboot_test("reboot design 13", 5'd13, 16'hC000, 16'h0324);
      reboot_test("reboot design 16", 5'd16, 16'h0000, 16'h0300);
      reboot_test("reboot design 6", 5'd6, 16'h4000, 16'h032F);
      backpressure_test();
      $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES)
      begin
         @(posedge clk_16M00);
         cycle_cnt++;
      end
      $display("Timeout: the DUT did not finish the tests within %0d cycles", MAX_CYCLES);
      $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/boot_image_table.sv
`default_nettype none
`timescale 1ns/1ps

`include "multiboot_defs.svh"

module boot_image_table
   import multiboot_pkg::*;
(
   input  wire logic        clk_16M00,
   input  wire logic        rst,
   input  wire logic        req_accept,
   input  wire design_num_t design_num,
   output boot_addr_t       boot_addr
);

   boot_addr_t entry;

   // GENERAL_1 holds the low address, GENERAL_2 the opcode and high address
   always_comb
   begin
      case (design_num)
         5'd16:           entry = '{gen1: 16'h0000, gen2: 16'h0300};
         5'd0:            entry = '{gen1: 16'h4000, gen2: 16'h0305};
         5'd1:            entry = '{gen1: 16'h8000, gen2: 16'h030A};
         5'd2:            entry = '{gen1: 16'hC000, gen2: 16'h030F};
         5'd3:            entry = '{gen1: 16'h0000, gen2: 16'h0315};
         5'd4:            entry = '{gen1: 16'h4000, gen2: 16'h031A};
         5'd5:            entry = '{gen1: 16'h8000, gen2: 16'h0334};
         5'd7:            entry = '{gen1: 16'h0000, gen2: 16'h032A};
         5'd8, 5'd9, 5'd10, 5'd11:
                          entry = '{gen1: 16'h8000, gen2: 16'h031F};
         5'd12, 5'd13, 5'd14, 5'd15:
                          entry = '{gen1: 16'hC000, gen2: 16'h0324};
         default:         entry = '{gen1: `BOOT_GEN1_DEFAULT, gen2: `BOOT_GEN2_DEFAULT};
      endcase
   end

   always_ff @(posedge clk_16M00)
   begin
      if (rst)
         boot_addr <= '{gen1: `BOOT_GEN1_DEFAULT, gen2: `BOOT_GEN2_DEFAULT};
      else if (req_accept)
         boot_addr <= entry;               // Held for the whole reboot
   end

   a_addr_hold: assert property (@(posedge clk_16M00) disable iff (rst)
      !$past(req_accept) |-> $stable(boot_addr));

endmodule

`default_nettype wire

//--- verilog/multiboot_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module multiboot_ctrl
   import icap_pkg::*;
   import multiboot_pkg::*;
(
   input  wire logic        clk_16M00,
   input  wire logic        rst,
   input  wire logic        reconfig_valid,
   output logic             reconfig_ready,
   input  wire design_num_t design_num,
   input  wire logic        powerup,
   input  wire logic [3:0]  sw_in,
   output logic [3:0]       sw_out,
   output logic [3:0]       pwr_out,
   output icap_word_t       icap_din,
   output logic             icap_ce,
   output logic             icap_wr,
   input  wire icap_word_t  icap_dout,
   input  wire logic        icap_busy
);

   logic       req_accept;
   boot_addr_t boot_addr;
   icap_word_t gen5_word;
   logic       dip_capture;
   soft_dip_t  dip_data;

   icap_sequencer icap_sequencer_i
   (
      .clk_16M00      (clk_16M00),
      .rst            (rst),
      .reconfig_valid (reconfig_valid),
      .reconfig_ready (reconfig_ready),
      .req_accept     (req_accept),
      .boot_addr      (boot_addr),
      .gen5_word      (gen5_word),
      .dip_capture    (dip_capture),
      .dip_data       (dip_data),
      .icap_din       (icap_din),
      .icap_ce        (icap_ce),
      .icap_wr        (icap_wr),
      .icap_dout      (icap_dout),
      .icap_busy      (icap_busy)
   );

   boot_image_table boot_image_table_i
   (
      .clk_16M00  (clk_16M00),
      .rst        (rst),
      .req_accept (req_accept),
      .design_num (design_num),
      .boot_addr  (boot_addr)
   );

   soft_dip_store soft_dip_store_i
   (
      .clk_16M00   (clk_16M00),
      .rst         (rst),
      .dip_capture (dip_capture),
      .dip_data    (dip_data),
      .req_accept  (req_accept),
      .design_num  (design_num),
      .powerup     (powerup),
      .sw_in       (sw_in),
      .sw_out      (sw_out),
      .pwr_out     (pwr_out),
      .gen5_word   (gen5_word)
   );

endmodule

`default_nettype wire

//--- verilog/soft_dip_store.sv
`default_nettype none
`timescale 1ns/1ps

`include "multiboot_defs.svh"

module soft_dip_store
   import icap_pkg::*;
   import multiboot_pkg::*;
(
   input  wire logic        clk_16M00,
   input  wire logic        rst,
   input  wire logic        dip_capture,
   input  wire soft_dip_t   dip_data,
   input  wire logic        req_accept,
   input  wire design_num_t design_num,
   input  wire logic        powerup,
   input  wire logic [3:0]  sw_in,
   output logic [3:0]       sw_out,
   output logic [3:0]       pwr_out,
   output icap_word_t       gen5_word
);

   soft_dip_t  soft_dip;
   logic [3:0] design_lo;

   always_ff @(posedge clk_16M00)
   begin
      if (rst)
         soft_dip <= '0;                   // Zero until readback lands
      else if (dip_capture)
         soft_dip <= dip_data;
   end

   always_ff @(posedge clk_16M00)
   begin
      if (req_accept)
         design_lo <= design_num[3:0];
   end

   // Physical switches win during powerup
   assign sw_out  = powerup ? sw_in : soft_dip.sw;
   assign pwr_out = powerup ? sw_in : soft_dip.pwr;

   // Next image sees its own number in the switch nibble
   assign gen5_word.raw = {{(`ICAP_W - `DIP_W){1'b0}},
                           powerup ? sw_in : soft_dip.pwr,
                           powerup ? sw_in : design_lo};

endmodule

`default_nettype wire
